// File: sha3_defines.svh
////////////////////////////////////////////////////////////
// SHA3_UNROLL must divide SHA3_NUM_ROUNDS
// Message width fixed at one 64-bit Keccak lane
////////////////////////////////////////////////////////////

`ifndef SHA3_DEFINES_SVH
`define SHA3_DEFINES_SVH

// Message word width in bits, one lane
`define SHA3_MSG_W 64

// Keccak-f[1600] state width
`define SHA3_STATE_W 1600

// Rounds in one permutation
`define SHA3_NUM_ROUNDS 24

// Round units per clock, 1 to 4
`define SHA3_UNROLL 1

`endif

// File: keccak_pkg.sv
////////////////////////////////////////////////////////////
// Lane i is x + 5*y, byte 0 of a lane is its low byte
////////////////////////////////////////////////////////////

`default_nettype none

`include "sha3_defines.svh"

package keccak_pkg;

  // State as 25 lanes of 8 bytes
  typedef logic [`SHA3_STATE_W/64-1:0][7:0][7:0] keccak_state_t;

  // Round number within one permutation
  typedef logic [4:0] round_idx_t;

  ////////////////////////////////////////////////////////////
  // Constants
  ////////////////////////////////////////////////////////////

  // Iota constants, one per round
  localparam logic [63:0] keccak_rc [24] = '{
    64'h0000_0000_0000_0001, 64'h0000_0000_0000_8082,
    64'h8000_0000_0000_808a, 64'h8000_0000_8000_8000,
    64'h0000_0000_0000_808b, 64'h0000_0000_8000_0001,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8009,
    64'h0000_0000_0000_008a, 64'h0000_0000_0000_0088,
    64'h0000_0000_8000_8009, 64'h0000_0000_8000_000a,
    64'h0000_0000_8000_808b, 64'h8000_0000_0000_008b,
    64'h8000_0000_0000_8089, 64'h8000_0000_0000_8003,
    64'h8000_0000_0000_8002, 64'h8000_0000_0000_0080,
    64'h0000_0000_0000_800a, 64'h8000_0000_8000_000a,
    64'h8000_0000_8000_8081, 64'h8000_0000_0000_8080,
    64'h0000_0000_8000_0001, 64'h8000_0000_8000_8008
  };

  // Rho offsets, indexed by x + 5*y
  localparam int unsigned keccak_rot [25] = '{
     0,  1, 62, 28, 27,
    36, 44,  6, 55, 20,
     3, 10, 43, 25, 39,
    41, 45, 15, 21,  8,
    18,  2, 61, 56, 14
  };

endpackage

`default_nettype wire

// File: sha3_pkg.sv
////////////////////////////////////////////////////////////
// Only SHA3 and SHAKE, no cSHAKE prefix
////////////////////////////////////////////////////////////

`default_nettype none

`include "sha3_defines.svh"

package sha3_pkg;

  // Domain byte 0x06 for SHA3, 0x1F for SHAKE
  typedef enum logic {
    Sha3  = 1'b0,
    Shake = 1'b1
  } sha3_mode_e;

  // Security strength picks the rate
  typedef enum logic [1:0] {
    L128 = 2'd0,
    L256 = 2'd1,
    L512 = 2'd2
  } keccak_strength_e;

  // Message word with low-byte strobe
  typedef struct packed {
    logic [`SHA3_MSG_W-1:0]   data;
    logic [`SHA3_MSG_W/8-1:0] strb;
  } msg_word_t;

  // Control FSM states
  typedef enum logic [2:0] {
    StIdle,
    StAbsorb,
    StSqueeze,
    StManualRun,
    StFlush
  } sha3_st_e;

  typedef enum logic {
    ErrNone,
    ErrSwControl
  } err_code_e;

  // Info holds {done, run, process, start}
  typedef struct packed {
    logic       valid;
    err_code_e  code;
    logic [3:0] info;
  } sha3_err_t;

  // Rate in bytes for a strength
  function automatic logic [7:0] sha3_rate_bytes(keccak_strength_e strength);
    unique case (strength)
      L128:    sha3_rate_bytes = 8'd168;
      L512:    sha3_rate_bytes = 8'd72;
      default: sha3_rate_bytes = 8'd136;
    endcase
  endfunction

endpackage

`default_nettype wire

// File: keccak_round.sv
////////////////////////////////////////////////////////////
// Purely combinational, round_i must stay below 24
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module keccak_round
  import keccak_pkg::*;
(
  input  keccak_state_t state_i,
  input  round_idx_t    round_i,
  output keccak_state_t state_o
);

  // Left rotation of one lane
  function automatic logic [63:0] rotl64(logic [63:0] v, int unsigned n);
    rotl64 = (n == 0) ? v : ((v << n) | (v >> (64 - n)));
  endfunction

  // Column parities and theta terms
  logic [63:0] c [5];
  logic [63:0] d [5];
  // Lanes after theta, after rho/pi, after chi
  logic [63:0] a [25];
  logic [63:0] b [25];
  logic [63:0] e [25];

  always_comb begin
    // Theta
    for (int x = 0; x < 5; x++) begin
      c[x] = state_i[x] ^ state_i[x+5] ^ state_i[x+10] ^ state_i[x+15] ^ state_i[x+20];
    end
    for (int x = 0; x < 5; x++) begin
      d[x] = c[(x+4)%5] ^ rotl64(c[(x+1)%5], 1);
    end
    for (int i = 0; i < 25; i++) begin
      a[i] = state_i[i] ^ d[i%5];
    end

    // Rho and pi, lane (x,y) lands at (y, 2x+3y)
    for (int x = 0; x < 5; x++) begin
      for (int y = 0; y < 5; y++) begin
        b[y + 5*((2*x + 3*y) % 5)] = rotl64(a[x + 5*y], keccak_rot[x + 5*y]);
      end
    end

    // Chi along each row
    for (int y = 0; y < 5; y++) begin
      for (int x = 0; x < 5; x++) begin
        e[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
      end
    end

    // Iota on lane 0 only
    e[0] = e[0] ^ keccak_rc[round_i];

    for (int i = 0; i < 25; i++) begin
      state_o[i] = e[i];
    end
  end

endmodule

`default_nettype wire

// File: keccak_perm.sv
////////////////////////////////////////////////////////////
// Writes are dropped while running, caller must honor ready
// complete_o comes 24/SHA3_UNROLL cycles after run_i
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sha3_defines.svh"

module keccak_perm
  import keccak_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Absorb port, word XORed into one lane
  input  logic                   wr_valid_i,
  input  logic [4:0]             wr_addr_i,
  input  logic [`SHA3_MSG_W-1:0] wr_data_i,
  output logic                   wr_ready_o,

  input  logic                   run_i,
  input  logic                   clear_i,
  output logic                   complete_o,
  output keccak_state_t          state_o
);

  // Counter value in the last running cycle
  localparam round_idx_t LastRound = round_idx_t'(`SHA3_NUM_ROUNDS - `SHA3_UNROLL);

  keccak_state_t state_q;
  round_idx_t    round_q;
  logic          running_q;

  // Round chain, entry k feeds unit k
  keccak_state_t chain [`SHA3_UNROLL+1];

  assign chain[0] = state_q;

  for (genvar k = 0; k < `SHA3_UNROLL; k++) begin : gen_rounds
    keccak_round u_round (
      .state_i (chain[k]),
      .round_i (round_q + round_idx_t'(k)),
      .state_o (chain[k+1])
    );
  end

  assign wr_ready_o = !running_q;
  assign complete_o = running_q && (round_q == LastRound);
  assign state_o    = state_q;

  // Round counter and busy flag
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      running_q <= 1'b0;
      round_q   <= '0;
    end else if (running_q) begin
      if (complete_o) begin
        running_q <= 1'b0;
        round_q   <= '0;
      end else begin
        round_q <= round_q + round_idx_t'(`SHA3_UNROLL);
      end
    end else if (run_i) begin
      running_q <= 1'b1;
      round_q   <= '0;
    end
  end

  // State update, clear wins over everything
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else if (clear_i) begin
      state_q <= '0;
    end else if (running_q) begin
      state_q <= chain[`SHA3_UNROLL];
    end else if (wr_valid_i) begin
      state_q[wr_addr_i] <= state_q[wr_addr_i] ^ wr_data_i;
    end
  end

endmodule

`default_nettype wire

// File: sha3_pad.sv
////////////////////////////////////////////////////////////
// Strobe is contiguous from byte 0, only the last word partial
// mode_i and strength_i must hold from start to absorbed
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sha3_defines.svh"

module sha3_pad
  import sha3_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // Message stream
  input  logic                   msg_valid_i,
  input  msg_word_t              msg_i,
  output logic                   msg_ready_o,

  input  sha3_mode_e             mode_i,
  input  keccak_strength_e       strength_i,

  // Filtered controls
  input  logic                   start_i,
  input  logic                   process_i,
  input  logic                   done_i,

  // Towards the permutation
  output logic                   wr_valid_o,
  output logic [4:0]             wr_addr_o,
  output logic [`SHA3_MSG_W-1:0] wr_data_o,
  input  logic                   wr_ready_i,
  output logic                   run_o,
  input  logic                   complete_i,

  output logic                   absorbed_o
);

  typedef enum logic [2:0] {
    PadIdle,
    PadAbsorb,
    PadWaitRun,
    PadPad,
    PadWaitFinal
  } pad_st_e;

  pad_st_e st_q, st_d;
  // Byte offset within the current block
  logic [7:0] offset_q, offset_d;
  logic       step_q, step_d;
  logic       run_q, run_d;
  logic       absorbed_q, absorbed_d;
  logic       proc_q;

  logic [7:0]             rate;
  logic [7:0]             last_byte;
  logic [7:0]             domain;
  logic [7:0]             msg_bytes;
  logic [`SHA3_MSG_W-1:0] msg_mask;
  logic [`SHA3_MSG_W-1:0] pad_first;
  logic                   msg_fire;
  logic                   wr_fire;
  logic                   same_word;

  assign rate      = sha3_rate_bytes(strength_i);
  assign last_byte = rate - 8'd1;
  assign domain    = (mode_i == Shake) ? 8'h1f : 8'h06;
  // Domain byte and final 0x80 share a word
  assign same_word = (offset_q[7:3] == last_byte[7:3]);

  // Bytes carried by this word
  assign msg_bytes = 8'($countones(msg_i.strb));

  always_comb begin
    for (int i = 0; i < `SHA3_MSG_W/8; i++) begin
      msg_mask[8*i +: 8] = {8{msg_i.strb[i]}};
    end
  end

  // First padding word, maybe also the last
  always_comb begin
    pad_first = '0;
    pad_first[{offset_q[2:0], 3'b000} +: 8] = domain;
    if (same_word) begin
      pad_first[`SHA3_MSG_W-1 -: 8] = pad_first[`SHA3_MSG_W-1 -: 8] ^ 8'h80;
    end
  end

  ////////////////////////////////////////////////////////////
  // Write port
  ////////////////////////////////////////////////////////////

  assign msg_ready_o = (st_q == PadAbsorb) && wr_ready_i && !proc_q;
  assign msg_fire    = msg_valid_i && msg_ready_o;

  always_comb begin
    wr_valid_o = 1'b0;
    wr_addr_o  = offset_q[7:3];
    wr_data_o  = msg_i.data & msg_mask;
    if (st_q == PadAbsorb) begin
      wr_valid_o = msg_fire;
    end else if (st_q == PadPad) begin
      wr_valid_o = 1'b1;
      if (step_q) begin
        // Separate word holding only 0x80
        wr_addr_o = last_byte[7:3];
        wr_data_o = {8'h80, {(`SHA3_MSG_W-8){1'b0}}};
      end else begin
        wr_data_o = pad_first;
      end
    end
  end

  assign wr_fire = wr_valid_o && wr_ready_i;

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    st_d       = st_q;
    offset_d   = offset_q;
    step_d     = step_q;
    run_d      = 1'b0;
    absorbed_d = 1'b0;

    unique case (st_q)
      PadIdle: begin
        if (start_i) begin
          st_d     = PadAbsorb;
          offset_d = '0;
        end
      end

      PadAbsorb: begin
        if (msg_fire) begin
          offset_d = offset_q + msg_bytes;
          // Block full, permute before more input
          if (offset_d == rate) begin
            offset_d = '0;
            run_d    = 1'b1;
            st_d     = PadWaitRun;
          end
        end else if (proc_q) begin
          st_d   = PadPad;
          step_d = 1'b0;
        end
      end

      PadWaitRun: begin
        if (complete_i) begin
          st_d = PadAbsorb;
        end
      end

      PadPad: begin
        if (wr_fire) begin
          if (step_q || same_word) begin
            step_d = 1'b0;
            run_d  = 1'b1;
            st_d   = PadWaitFinal;
          end else begin
            step_d = 1'b1;
          end
        end
      end

      PadWaitFinal: begin
        if (complete_i) begin
          absorbed_d = 1'b1;
          st_d       = PadIdle;
        end
      end

      default: st_d = PadIdle;
    endcase

    // Done flushes any leftover state
    if (done_i) begin
      st_d     = PadIdle;
      offset_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= PadIdle;
      offset_q   <= '0;
      step_q     <= 1'b0;
      run_q      <= 1'b0;
      absorbed_q <= 1'b0;
    end else begin
      st_q       <= st_d;
      offset_q   <= offset_d;
      step_q     <= step_d;
      run_q      <= run_d;
      absorbed_q <= absorbed_d;
    end
  end

  // Process seen, stop taking words
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      proc_q <= 1'b0;
    end else if (start_i || done_i) begin
      proc_q <= 1'b0;
    end else if (process_i) begin
      proc_q <= 1'b1;
    end
  end

  assign run_o      = run_q;
  assign absorbed_o = absorbed_q;

endmodule

`default_nettype wire

// File: sha3_ctrl.sv
////////////////////////////////////////////////////////////
// Software pulses are single cycle, illegal ones are dropped
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module sha3_ctrl
  import sha3_pkg::*;
  import keccak_pkg::*;
(
  input  logic          clk_i,
  input  logic          rst_ni,

  // Software pulses
  input  logic          start_i,
  input  logic          process_i,
  input  logic          run_i,
  input  logic          done_i,

  input  logic          absorbed_i,
  input  logic          complete_i,
  input  keccak_state_t state_i,

  // Filtered pulses
  output logic          pad_start_o,
  output logic          pad_process_o,
  output logic          pad_done_o,
  output logic          sw_run_o,

  output logic          absorbed_o,
  output logic          squeezing_o,
  output logic          state_valid_o,
  output keccak_state_t state_o,
  output sha3_st_e      fsm_o,
  output sha3_err_t     error_o
);

  sha3_st_e   st_q, st_d;
  // Process accepted for this message
  logic       processing_q;
  logic       absorbed_q;
  logic       illegal;
  logic [3:0] pulses;

  assign pulses = {done_i, run_i, process_i, start_i};

  ////////////////////////////////////////////////////////////
  // FSM
  ////////////////////////////////////////////////////////////

  always_comb begin
    st_d          = st_q;
    pad_start_o   = 1'b0;
    pad_process_o = 1'b0;
    pad_done_o    = 1'b0;
    sw_run_o      = 1'b0;

    unique case (st_q)
      StIdle: begin
        if (start_i) begin
          st_d        = StAbsorb;
          pad_start_o = 1'b1;
        end
      end

      StAbsorb: begin
        if (process_i && !processing_q) begin
          pad_process_o = 1'b1;
        end else if (absorbed_i) begin
          st_d = StSqueeze;
        end
      end

      // State visible, software may permute again or finish
      StSqueeze: begin
        if (run_i) begin
          st_d     = StManualRun;
          sw_run_o = 1'b1;
        end else if (done_i) begin
          st_d       = StFlush;
          pad_done_o = 1'b1;
        end
      end

      StManualRun: begin
        if (complete_i) begin
          st_d = StSqueeze;
        end
      end

      StFlush: st_d = StIdle;

      default: st_d = StIdle;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      st_q       <= StIdle;
      absorbed_q <= 1'b0;
    end else begin
      st_q       <= st_d;
      absorbed_q <= absorbed_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      processing_q <= 1'b0;
    end else if (pad_process_o) begin
      processing_q <= 1'b1;
    end else if (absorbed_i || pad_start_o) begin
      processing_q <= 1'b0;
    end
  end

  ////////////////////////////////////////////////////////////
  // Error detection
  ////////////////////////////////////////////////////////////

  // Any pulse not allowed in the current state
  always_comb begin
    unique case (st_q)
      StIdle:    illegal = process_i | run_i | done_i;
      StAbsorb:  illegal = start_i | run_i | done_i | (process_i & processing_q);
      StSqueeze: illegal = start_i | process_i;
      default:   illegal = |pulses;
    endcase
  end

  always_comb begin
    error_o.valid = illegal;
    error_o.code  = illegal ? ErrSwControl : ErrNone;
    error_o.info  = illegal ? pulses : 4'h0;
  end

  // Outputs, state released only in squeeze
  assign absorbed_o    = absorbed_q;
  assign squeezing_o   = (st_q == StSqueeze);
  assign state_valid_o = (st_q == StSqueeze);
  assign state_o       = state_valid_o ? state_i : '0;
  assign fsm_o         = st_q;

endmodule

`default_nettype wire

// File: sha3_top.sv
////////////////////////////////////////////////////////////
// Digest is read from state_o while state_valid_o is high
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sha3_defines.svh"

module sha3_top
  import sha3_pkg::*;
  import keccak_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_ni,

  input  logic             msg_valid_i,
  input  msg_word_t        msg_i,
  output logic             msg_ready_o,

  input  sha3_mode_e       mode_i,
  input  keccak_strength_e strength_i,

  input  logic             start_i,
  input  logic             process_i,
  input  logic             run_i,
  input  logic             done_i,

  output logic             absorbed_o,
  output logic             squeezing_o,
  output logic             state_valid_o,
  output keccak_state_t    state_o,
  output sha3_st_e         fsm_o,
  output sha3_err_t        error_o
);

  // Control to pad
  logic pad_start, pad_process, pad_done;
  logic pad_absorbed;

  // Pad to permutation
  logic                   wr_valid;
  logic [4:0]             wr_addr;
  logic [`SHA3_MSG_W-1:0] wr_data;
  logic                   wr_ready;

  // Run from padding or from software in squeeze
  logic          pad_run, sw_run, keccak_run;
  logic          keccak_complete;
  keccak_state_t keccak_state;

  assign keccak_run = pad_run | sw_run;

  sha3_ctrl u_ctrl (
    .clk_i,
    .rst_ni,
    .start_i,
    .process_i,
    .run_i,
    .done_i,
    .absorbed_i    (pad_absorbed),
    .complete_i    (keccak_complete),
    .state_i       (keccak_state),
    .pad_start_o   (pad_start),
    .pad_process_o (pad_process),
    .pad_done_o    (pad_done),
    .sw_run_o      (sw_run),
    .absorbed_o,
    .squeezing_o,
    .state_valid_o,
    .state_o,
    .fsm_o,
    .error_o
  );

  sha3_pad u_pad (
    .clk_i,
    .rst_ni,
    .msg_valid_i,
    .msg_i,
    .msg_ready_o,
    .mode_i,
    .strength_i,
    .start_i    (pad_start),
    .process_i  (pad_process),
    .done_i     (pad_done),
    .wr_valid_o (wr_valid),
    .wr_addr_o  (wr_addr),
    .wr_data_o  (wr_data),
    .wr_ready_i (wr_ready),
    .run_o      (pad_run),
    .complete_i (keccak_complete),
    .absorbed_o (pad_absorbed)
  );

  // Done also wipes the state for the next hash
  keccak_perm u_perm (
    .clk_i,
    .rst_ni,
    .wr_valid_i (wr_valid),
    .wr_addr_i  (wr_addr),
    .wr_data_i  (wr_data),
    .wr_ready_o (wr_ready),
    .run_i      (keccak_run),
    .clear_i    (pad_done),
    .complete_o (keccak_complete),
    .state_o    (keccak_state)
  );

endmodule

`default_nettype wire

// File: tb_sha3.sv
////////////////////////////////////////////////////////////
// Checked against a behavioral Keccak sponge model
// Digest read at absorbed_o, no output beyond the raw state
////////////////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "sha3_defines.svh"

module tb_sha3
  import sha3_pkg::*;
();

  localparam int ClkPeriod  = 40;
  // Hashes plus the idle error pulses
  localparam int NumMsgs    = 40;
  localparam int MaxBlocks  = 4;
  localparam int WaitCycles = 400;
  localparam longint TimeoutNs = longint'(NumMsgs) * (MaxBlocks * 30 + 100) * ClkPeriod;

  typedef logic [7:0] byte_q_t [$];
  typedef logic [`SHA3_STATE_W-1:0] state_t;

  logic             clk;
  logic             rst_n;
  logic             msg_valid;
  msg_word_t        msg;
  logic             msg_ready;
  sha3_mode_e       mode;
  keccak_strength_e strength;
  logic             start;
  logic             proc;
  logic             run;
  logic             done;
  logic             absorbed;
  logic             squeezing;
  logic             state_valid;
  state_t           state;
  sha3_st_e         fsm;
  sha3_err_t        err;

  integer      seed;
  // Model tables, built from the LFSR and the rho walk
  logic [63:0] rc_tab [24];
  int unsigned rot_tab [25];
  state_t      exp_q [$];
  int          sent;
  int          checked;

  sha3_top dut_i (
    .clk_i         (clk),
    .rst_ni        (rst_n),
    .msg_valid_i   (msg_valid),
    .msg_i         (msg),
    .msg_ready_o   (msg_ready),
    .mode_i        (mode),
    .strength_i    (strength),
    .start_i       (start),
    .process_i     (proc),
    .run_i         (run),
    .done_i        (done),
    .absorbed_o    (absorbed),
    .squeezing_o   (squeezing),
    .state_valid_o (state_valid),
    .state_o       (state),
    .fsm_o         (fsm),
    .error_o       (err)
  );

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  function automatic logic [63:0] rotl(logic [63:0] v, int unsigned n);
    if (n == 0) begin
      return v;
    end
    return (v << n) | (v >> (64 - n));
  endfunction

  task automatic build_tables();
    logic [7:0] lfsr;
    int x;
    int y;
    int tmp;
    // Round constants from the x^8+x^6+x^5+x^4+1 LFSR
    lfsr = 8'h01;
    for (int r = 0; r < 24; r++) begin
      rc_tab[r] = '0;
      for (int j = 0; j < 7; j++) begin
        if (lfsr[0]) begin
          rc_tab[r][(1 << j) - 1] = 1'b1;
        end
        lfsr = lfsr[7] ? ((lfsr << 1) ^ 8'h71) : (lfsr << 1);
      end
    end
    // Triangular offsets along the (x,y) -> (y,2x+3y) walk
    rot_tab[0] = 0;
    x = 1;
    y = 0;
    for (int t = 0; t < 24; t++) begin
      rot_tab[x + 5*y] = ((t + 1) * (t + 2) / 2) % 64;
      tmp = y;
      y   = (2*x + 3*y) % 5;
      x   = tmp;
    end
  endtask

  function automatic state_t keccak_f(state_t s);
    logic [63:0] a [25];
    logic [63:0] b [25];
    logic [63:0] c [5];
    logic [63:0] d;
    state_t      res;
    for (int i = 0; i < 25; i++) begin
      a[i] = s[64*i +: 64];
    end
    for (int r = 0; r < `SHA3_NUM_ROUNDS; r++) begin
      for (int x = 0; x < 5; x++) begin
        c[x] = a[x] ^ a[x+5] ^ a[x+10] ^ a[x+15] ^ a[x+20];
      end
      for (int x = 0; x < 5; x++) begin
        d = c[(x+4)%5] ^ rotl(c[(x+1)%5], 1);
        for (int y = 0; y < 5; y++) begin
          a[x + 5*y] ^= d;
        end
      end
      for (int x = 0; x < 5; x++) begin
        for (int y = 0; y < 5; y++) begin
          b[y + 5*((2*x + 3*y) % 5)] = rotl(a[x + 5*y], rot_tab[x + 5*y]);
        end
      end
      for (int y = 0; y < 5; y++) begin
        for (int x = 0; x < 5; x++) begin
          a[x + 5*y] = b[x + 5*y] ^ (~b[(x+1)%5 + 5*y] & b[(x+2)%5 + 5*y]);
        end
      end
      a[0] ^= rc_tab[r];
    end
    for (int i = 0; i < 25; i++) begin
      res[64*i +: 64] = a[i];
    end
    return res;
  endfunction

  // Rate is the state minus twice the security strength
  function automatic int rate_of(keccak_strength_e st);
    int sec;
    case (st)
      L128:    sec = 128;
      L512:    sec = 512;
      default: sec = 256;
    endcase
    return (1600 - 2*sec) / 8;
  endfunction

  function automatic logic [7:0] domain_of(sha3_mode_e md);
    return (md == Shake) ? 8'h1f : 8'h06;
  endfunction

  // Full sponge absorb with domain and final pad bits
  function automatic state_t keccak_ref(byte_q_t m, int rate, logic [7:0] dom);
    state_t s;
    int     pos;
    s   = '0;
    pos = 0;
    for (int i = 0; i < m.size(); i++) begin
      s[8*pos +: 8] ^= m[i];
      pos++;
      if (pos == rate) begin
        s   = keccak_f(s);
        pos = 0;
      end
    end
    s[8*pos +: 8]        ^= dom;
    s[8*(rate-1) +: 8]   ^= 8'h80;
    return keccak_f(s);
  endfunction

  function automatic int rand_below(int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  ////////////////////////////////////////////////////////////
  // Checks and stimulus
  ////////////////////////////////////////////////////////////

  task automatic fail_now(string why);
    $display("%s", why);
    $display("TEST FAILED");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(state_t got, state_t exp, string what);
    if (got !== exp) begin
      fail_now($sformatf("FAILED at %0t ns: %s, got %0h expected %0h", $time, what, got, exp));
    end
  endtask

  // Bits are {done, run, process, start}
  task automatic pulse(logic [3:0] bits, logic illegal);
    @(negedge clk);
    {done, run, proc, start} = bits;
    #(ClkPeriod / 4);
    check_eq(err.valid, illegal, "error_o.valid");
    if (illegal) begin
      check_eq(err.code, ErrSwControl, "error_o.code");
      check_eq(err.info, bits, "error_o.info");
    end
    @(negedge clk);
    {done, run, proc, start} = 4'b0000;
  endtask

  // Words with random gaps, junk above the strobe
  task automatic send_msg(byte_q_t m);
    int idx;
    int n;
    int stall;
    idx   = 0;
    stall = 0;
    while (idx < m.size()) begin
      @(negedge clk);
      check_eq(state_valid, 1'b0, "state_valid_o high while absorbing");
      if (($random(seed) & 3) == 0) begin
        msg_valid = 1'b0;
      end else begin
        n        = (m.size() - idx > 8) ? 8 : m.size() - idx;
        msg.data = {$random(seed), $random(seed)};
        msg.strb = '0;
        for (int k = 0; k < n; k++) begin
          msg.data[8*k +: 8] = m[idx + k];
          msg.strb[k]        = 1'b1;
        end
        msg_valid = 1'b1;
      end
      // Ready has no path from valid, stable here
      if (msg_valid && msg_ready) begin
        idx  += 8;
        stall = 0;
      end else begin
        stall++;
        if (stall > WaitCycles) begin
          fail_now("msg_ready_o stayed low while a word was waiting");
        end
      end
    end
    @(negedge clk);
    msg_valid = 1'b0;
  endtask

  task automatic wait_absorbed();
    int n;
    n = 0;
    @(negedge clk);
    while (!absorbed) begin
      n++;
      if (n > WaitCycles) begin
        fail_now("absorbed_o never came after process");
      end
      @(negedge clk);
    end
    check_eq(state_valid, 1'b1, "state_valid_o at absorbed_o");
    check_eq(squeezing, 1'b1, "squeezing_o at absorbed_o");
  endtask

  task automatic hash_msg(input sha3_mode_e md, input keccak_strength_e st, input int len,
                          input logic inject, output state_t digest);
    byte_q_t m;
    m = {};
    for (int i = 0; i < len; i++) begin
      m.push_back(8'($random(seed)));
    end
    @(negedge clk);
    mode     = md;
    strength = st;
    digest   = keccak_ref(m, rate_of(st), domain_of(md));
    exp_q.push_back(digest);
    sent++;
    pulse(4'b0001, 1'b0);
    if (inject) begin
      pulse(4'b0001, 1'b1);
      check_eq(fsm, StAbsorb, "FSM after start in absorb");
    end
    send_msg(m);
    pulse(4'b0010, 1'b0);
    if (inject) begin
      // Second process for the same message
      pulse(4'b0010, 1'b1);
      check_eq(fsm, StAbsorb, "FSM after second process");
    end
    wait_absorbed();
  endtask

  // One more Keccak-f from squeeze
  task automatic manual_run(inout state_t st);
    int n;
    pulse(4'b0100, 1'b0);
    check_eq(state_valid, 1'b0, "state_valid_o during manual run");
    st = keccak_f(st);
    n  = 0;
    while (!state_valid) begin
      n++;
      if (n > WaitCycles) begin
        fail_now("manual run never returned to squeeze");
      end
      @(negedge clk);
    end
    check_eq(state, st, "state after manual run");
  endtask

  task automatic finish_hash();
    pulse(4'b1000, 1'b0);
    @(negedge clk);
    check_eq(fsm, StIdle, "FSM after done");
    check_eq(state_valid, 1'b0, "state_valid_o after done");
  endtask

  // Compare process, state gating every cycle and digest per hash
  initial begin
    forever begin
      @(negedge clk);
      if (!state_valid) begin
        check_eq(state, '0, "state_o outside squeeze");
      end
      if (absorbed) begin
        if (exp_q.size() == 0) begin
          fail_now("absorbed_o pulsed with no message pending");
        end
        check_eq(state, exp_q.pop_front(), "digest at absorbed_o");
        checked++;
      end
    end
  end

  // Watchdog
  initial begin
    #(TimeoutNs);
    fail_now($sformatf("watchdog expired after %0d ns", TimeoutNs));
  end

  initial begin
    state_t dig;
    int     rate;
    int     lens [6];
    seed      = 32'h1f9c_c7a3;
    sent      = 0;
    checked   = 0;
    rst_n     = 1'b0;
    msg_valid = 1'b0;
    msg       = '0;
    mode      = Sha3;
    strength  = L256;
    start     = 1'b0;
    proc      = 1'b0;
    run       = 1'b0;
    done      = 1'b0;
    build_tables();

    repeat (5) @(posedge clk);
    @(negedge clk);
    check_eq(msg_ready, 1'b0, "msg_ready_o in reset");
    check_eq(absorbed, 1'b0, "absorbed_o in reset");
    check_eq(squeezing, 1'b0, "squeezing_o in reset");
    check_eq(state_valid, 1'b0, "state_valid_o in reset");
    check_eq(err.valid, 1'b0, "error_o.valid in reset");
    rst_n = 1'b1;

    // Illegal pulses in idle
    pulse(4'b0010, 1'b1);
    check_eq(fsm, StIdle, "FSM after process in idle");
    pulse(4'b1000, 1'b1);
    check_eq(fsm, StIdle, "FSM after done in idle");

    // Every mode and strength, edge and random lengths
    for (int md = 0; md < 2; md++) begin
      for (int s = 0; s < 3; s++) begin
        rate = rate_of(keccak_strength_e'(s));
        lens = '{0, rate, 2*rate, rate - 1, rate - 5, rand_below(3*rate)};
        for (int k = 0; k < 6; k++) begin
          hash_msg(sha3_mode_e'(md), keccak_strength_e'(s), lens[k], 1'b0, dig);
          if (k == 3) begin
            manual_run(dig);
            manual_run(dig);
          end
          finish_hash();
        end
      end
    end

    // Injected errors must not disturb the digest
    hash_msg(Shake, L128, rate_of(L128) + 13, 1'b1, dig);
    pulse(4'b0001, 1'b1);
    check_eq(fsm, StSqueeze, "FSM after start in squeeze");
    check_eq(state, dig, "state after start in squeeze");
    pulse(4'b0010, 1'b1);
    check_eq(state, dig, "state after process in squeeze");
    finish_hash();

    @(negedge clk);
    if (sent == checked && exp_q.size() == 0) begin
      $display("TEST PASSED");
      $finish;
    end else begin
      fail_now("not every message produced a digest");
    end
  end

endmodule

`default_nettype wire

// File: all.f
+incdir+.
keccak_pkg.sv
sha3_pkg.sv
keccak_round.sv
keccak_perm.sv
sha3_pad.sv
sha3_ctrl.sv
sha3_top.sv
tb_sha3.sv

// File: Bender.yml
package:
  name: sha3_core

sources:
  - include_dirs:
      - .
    files:
      - keccak_pkg.sv
      - sha3_pkg.sv
      - keccak_round.sv
      - keccak_perm.sv
      - sha3_pad.sv
      - sha3_ctrl.sv
      - sha3_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_sha3.sv
